//--- include/uart_echo_config.svh
`ifndef UART_ECHO_CONFIG_SVH
`define UART_ECHO_CONFIG_SVH

//////////////////////////////////////////////////
// Serial timing
//////////////////////////////////////////////////

// Clock cycles per serial bit
`define UART_ECHO_CLKS_PER_BIT 16

// Mid-bit sampling offset from the start edge
`define UART_ECHO_HALF_BIT 8

//////////////////////////////////////////////////
// Queue sizing
//////////////////////////////////////////////////

// Entries per FIFO, power of two
`define UART_ECHO_FIFO_DEPTH 8

`endif

//--- logic/uart_echo_pkg.sv
`default_nettype none

package uart_echo_pkg;

	// One serial data byte
	typedef logic [7:0] uart_byte_t;

	// Receive FIFO entry
	// Data byte plus stop-bit status of its frame
	typedef struct packed
	{
		uart_byte_t data;
		logic       framing_error;
	} rx_entry_t;

	// Relay FSM states
	// Read, hold and write steps of the echo relay
	typedef enum logic [1:0]
	{
		RELAY_IDLE  = 2'b00,
		RELAY_READ  = 2'b01,
		RELAY_HOLD  = 2'b10,
		RELAY_WRITE = 2'b11
	} relay_state_t;

endpackage

`default_nettype wire

//--- logic/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_echo_config.svh"

module uart_rx
	import uart_echo_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  logic      rxd,
	input  logic      rx_full,
	output logic      rx_wr,
	output rx_entry_t rx_wdata
);

	localparam int CNT_W = $clog2(`UART_ECHO_CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(`UART_ECHO_HALF_BIT - 1);
	localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(`UART_ECHO_CLKS_PER_BIT - 1);

	typedef enum logic [1:0]
	{
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t        state;
	logic [CNT_W-1:0] cnt;
	logic [2:0]       bit_idx;
	uart_byte_t       shift_reg;

	logic rxd_meta;
	logic rxd_sync;
	logic rxd_prev;
	logic start_edge;
	logic half_tick;
	logic bit_tick;

	//////////////////////////////////////////////////
	// Input synchronizer and edge detect
	//////////////////////////////////////////////////

	// Idle line is high, so reset to high
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end
		else
		begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	// High to low on the synced line
	assign start_edge = rxd_prev && !rxd_sync;

	// Sample points
	// Start bit checked half a bit in, then one full bit apart
	assign half_tick = (cnt == HALF_LAST);
	assign bit_tick  = (cnt == BIT_LAST);

	//////////////////////////////////////////////////
	// Frame FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state   <= RX_IDLE;
			cnt     <= '0;
			bit_idx <= '0;
			rx_wr   <= 1'b0;
		end
		else
		begin
			// Write strobe is a single cycle
			rx_wr <= 1'b0;
			case (state)
				RX_IDLE:
				begin
					if (start_edge)
					begin
						state <= RX_START;
						cnt   <= '0;
					end
				end
				RX_START:
				begin
					if (half_tick)
					begin
						cnt     <= '0;
						bit_idx <= '0;
						// Line back high at mid-bit means a glitch
						state   <= rxd_sync ? RX_IDLE : RX_DATA;
					end
					else
						cnt <= cnt + 1'b1;
				end
				RX_DATA:
				begin
					if (bit_tick)
					begin
						cnt     <= '0;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end
					else
						cnt <= cnt + 1'b1;
				end
				RX_STOP:
				begin
					if (bit_tick)
					begin
						cnt   <= '0;
						state <= RX_IDLE;
						// Frame lost when the queue has no room
						rx_wr <= !rx_full;
					end
					else
						cnt <= cnt + 1'b1;
				end
				default:
					state <= RX_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Data path
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		// LSB arrives first, shift in from the top
		if (state == RX_DATA && bit_tick)
			shift_reg <= {rxd_sync, shift_reg[7:1]};
		// Stop bit low flags the frame
		if (state == RX_STOP && bit_tick)
		begin
			rx_wdata.data          <= shift_reg;
			rx_wdata.framing_error <= !rxd_sync;
		end
	end

endmodule

`default_nettype wire

//--- logic/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_echo_config.svh"

module uart_tx
	import uart_echo_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       tx_empty,
	input  uart_byte_t tx_rdata,
	output logic       tx_rd,
	output logic       txd
);

	localparam int CNT_W = $clog2(`UART_ECHO_CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(`UART_ECHO_CLKS_PER_BIT - 1);

	logic             busy;
	logic [CNT_W-1:0] cnt;
	// Bits already on the line, start bit is 0, stop bit is 9
	logic [3:0]       bit_cnt;
	// Remaining bits, stop bit on top
	logic [8:0]       shreg;
	logic             bit_end;
	logic             last_tick;

	assign bit_end   = (cnt == BIT_LAST);
	assign last_tick = busy && bit_end && (bit_cnt == 4'd9);

	// Pop when idle or as the stop bit ends
	// Back-to-back frames then have no gap
	assign tx_rd = (!busy || last_tick) && !tx_empty;

	//////////////////////////////////////////////////
	// Bit timing and line driver
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			busy    <= 1'b0;
			txd     <= 1'b1;
			cnt     <= '0;
			bit_cnt <= '0;
		end
		else if (tx_rd)
		begin
			// Start bit on the cycle after the pop
			busy    <= 1'b1;
			txd     <= 1'b0;
			cnt     <= '0;
			bit_cnt <= '0;
		end
		else if (busy)
		begin
			if (bit_end)
			begin
				cnt <= '0;
				if (bit_cnt == 4'd9)
				begin
					busy <= 1'b0;
					txd  <= 1'b1;
				end
				else
				begin
					txd     <= shreg[0];
					bit_cnt <= bit_cnt + 4'd1;
				end
			end
			else
				cnt <= cnt + 1'b1;
		end
	end

	// Shift register
	always_ff @(posedge clk)
	begin
		if (tx_rd)
			shreg <= {1'b1, tx_rdata};
		else if (busy && bit_end && bit_cnt != 4'd9)
			shreg <= {1'b1, shreg[8:1]};
	end

endmodule

`default_nettype wire

//--- logic/byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module byte_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  depth     = 8
)
(
	input  logic     clk,
	input  logic     arst_n,
	input  logic     wr,
	input  payload_t wdata,
	output logic     full,
	input  logic     rd,
	output payload_t rdata,
	output logic     empty
);

	localparam int AW = $clog2(depth);

	payload_t mem [depth];

	// Extra top bit tells full from empty
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic        do_wr;
	logic        do_rd;

	// Guard against overflow and underflow
	assign do_wr = wr && !full;
	assign do_rd = rd && !empty;

	assign empty = (wr_ptr == rd_ptr);
	// Same slot, one lap apart
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
	               (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	// Head shown straight from storage
	assign rdata = mem[rd_ptr[AW-1:0]];

	//////////////////////////////////////////////////
	// Pointers
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			// Read and write may happen in the same cycle
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Storage
	always_ff @(posedge clk)
	begin
		if (do_wr)
			mem[wr_ptr[AW-1:0]] <= wdata;
	end

endmodule

`default_nettype wire

//--- logic/echo_relay.sv
`timescale 1ns/1ps
`default_nettype none

module echo_relay
	import uart_echo_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  rx_entry_t  rdata,
	input  logic       empty,
	output logic       rd,
	output uart_byte_t w_data,
	input  logic       full,
	output logic       wr
);

	relay_state_t state;
	relay_state_t next_state;
	// One entry in flight
	rx_entry_t    hold;

	//////////////////////////////////////////////////
	// Next state
	//////////////////////////////////////////////////

	always_comb
	begin
		next_state = state;
		case (state)
			RELAY_IDLE:
				if (!empty)
					next_state = RELAY_READ;
			// Pop lasts one cycle
			RELAY_READ:
				next_state = RELAY_HOLD;
			RELAY_HOLD:
			begin
				// Bad frames are dropped here
				if (hold.framing_error)
					next_state = RELAY_IDLE;
				else if (!full)
					next_state = RELAY_WRITE;
			end
			RELAY_WRITE:
				next_state = RELAY_IDLE;
			default:
				next_state = RELAY_IDLE;
		endcase
	end

	// State and strobes
	// Strobes decoded from next state, so they line up with their state
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= RELAY_IDLE;
			rd    <= 1'b0;
			wr    <= 1'b0;
		end
		else
		begin
			state <= next_state;
			rd    <= (next_state == RELAY_READ);
			wr    <= (next_state == RELAY_WRITE);
		end
	end

	// Head entry captured as it is popped
	always_ff @(posedge clk)
	begin
		if (state == RELAY_READ)
			hold <= rdata;
	end

	assign w_data = hold.data;

endmodule

`default_nettype wire

//--- logic/uart_echo_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_echo_config.svh"

module uart_echo_top
	import uart_echo_pkg::*;
(
	input  logic clk,
	input  logic arst_n,
	input  logic rxd,
	output logic txd
);

	// Receiver side
	logic       rx_wr;
	rx_entry_t  rx_wdata;
	logic       rx_full;

	// Relay read side
	logic       rx_rd;
	rx_entry_t  rx_rdata;
	logic       rx_empty;

	// Relay write side
	logic       tx_wr;
	uart_byte_t tx_wdata;
	logic       tx_full;

	// Transmitter side
	logic       tx_rd;
	uart_byte_t tx_rdata;
	logic       tx_empty;

	//////////////////////////////////////////////////
	// Receive path
	//////////////////////////////////////////////////

	uart_rx i_uart_rx (
		.clk      (clk),
		.arst_n   (arst_n),
		.rxd      (rxd),
		.rx_full  (rx_full),
		.rx_wr    (rx_wr),
		.rx_wdata (rx_wdata)
	);

	// Frames with status
	byte_fifo #(
		.payload_t (rx_entry_t),
		.depth     (`UART_ECHO_FIFO_DEPTH)
	) i_rx_fifo (
		.clk    (clk),
		.arst_n (arst_n),
		.wr     (rx_wr),
		.wdata  (rx_wdata),
		.full   (rx_full),
		.rd     (rx_rd),
		.rdata  (rx_rdata),
		.empty  (rx_empty)
	);

	// Filter between the queues
	echo_relay i_echo_relay (
		.clk    (clk),
		.arst_n (arst_n),
		.rdata  (rx_rdata),
		.empty  (rx_empty),
		.rd     (rx_rd),
		.w_data (tx_wdata),
		.full   (tx_full),
		.wr     (tx_wr)
	);

	//////////////////////////////////////////////////
	// Transmit path
	//////////////////////////////////////////////////

	// Plain bytes only
	byte_fifo #(
		.payload_t (uart_byte_t),
		.depth     (`UART_ECHO_FIFO_DEPTH)
	) i_tx_fifo (
		.clk    (clk),
		.arst_n (arst_n),
		.wr     (tx_wr),
		.wdata  (tx_wdata),
		.full   (tx_full),
		.rd     (tx_rd),
		.rdata  (tx_rdata),
		.empty  (tx_empty)
	);

	uart_tx i_uart_tx (
		.clk      (clk),
		.arst_n   (arst_n),
		.tx_empty (tx_empty),
		.tx_rdata (tx_rdata),
		.tx_rd    (tx_rd),
		.txd      (txd)
	);

endmodule

`default_nettype wire

//--- verification/uart_echo_assert.sv
`timescale 1ns/1ps
`default_nettype none

module uart_echo_assert #(
	// Serial line check in place of the handshake checks
	parameter bit line_check = 1'b0
)
(
	input logic clk,
	input logic arst_n,
	input logic rd,
	input logic empty,
	input logic wr,
	input logic full,
	input logic txd
);

	// Failed assertions so far
	int fail_count = 0;

	if (line_check)
	begin : g_line
		// Set by the first pop, cleared by reset
		logic popped;

		always_ff @(posedge clk or negedge arst_n)
		begin
			if (!arst_n)
				popped <= 1'b0;
			else if (rd)
				popped <= 1'b1;
		end

		// Line idles high until something is popped for sending
		txd_idle_until_pop: assert property (@(posedge clk) disable iff (!arst_n)
			!popped |-> txd)
			else
			begin
				$error("txd left idle before the first pop");
				fail_count++;
			end
	end
	else
	begin : g_handshake
		//////////////////////////////////////////////////
		// Handshake rules
		//////////////////////////////////////////////////

		// Pop only with data present
		rd_needs_data: assert property (@(posedge clk) disable iff (!arst_n)
			rd |-> !empty)
			else
			begin
				$error("rd asserted while empty");
				fail_count++;
			end

		// Push only with room left
		wr_needs_room: assert property (@(posedge clk) disable iff (!arst_n)
			wr |-> !full)
			else
			begin
				$error("wr asserted while full");
				fail_count++;
			end

		// Strobes last one cycle
		rd_single_cycle: assert property (@(posedge clk) disable iff (!arst_n)
			rd |=> !rd)
			else
			begin
				$error("rd held for more than one cycle");
				fail_count++;
			end

		wr_single_cycle: assert property (@(posedge clk) disable iff (!arst_n)
			wr |=> !wr)
			else
			begin
				$error("wr held for more than one cycle");
				fail_count++;
			end
	end

endmodule

//////////////////////////////////////////////////
// Attachments
//////////////////////////////////////////////////

bind echo_relay uart_echo_assert i_relay_assert (
	.clk    (clk),
	.arst_n (arst_n),
	.rd     (rd),
	.empty  (empty),
	.wr     (wr),
	.full   (full),
	.txd    (1'b1)
);

// Both queues
bind byte_fifo uart_echo_assert i_fifo_assert (
	.clk    (clk),
	.arst_n (arst_n),
	.rd     (rd),
	.empty  (empty),
	.wr     (wr),
	.full   (full),
	.txd    (1'b1)
);

// Transmitter pop against the line
bind uart_tx uart_echo_assert #(.line_check (1'b1)) i_tx_assert (
	.clk    (clk),
	.arst_n (arst_n),
	.rd     (tx_rd),
	.empty  (tx_empty),
	.wr     (1'b0),
	.full   (1'b0),
	.txd    (txd)
);

`default_nettype wire

//--- verification/uart_echo_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_echo_config.svh"

module uart_echo_tb
	import uart_echo_pkg::*;
();

	localparam int BIT_CYCLES   = `UART_ECHO_CLKS_PER_BIT;
	localparam int FRAME_CYCLES = 10 * `UART_ECHO_CLKS_PER_BIT;

	logic clk;
	logic arst_n;
	logic rxd;
	logic txd;

	// Bytes predicted and bytes seen on txd, both in order
	uart_byte_t  exp_q [$];
	uart_byte_t  got_q [$];
	logic        decoding;
	logic [31:0] rng_state;

	uart_echo_top i_uart_echo_top (
		.clk    (clk),
		.arst_n (arst_n),
		.rxd    (rxd),
		.txd    (txd)
	);

	// 20 ns period
	always #10 clk = ~clk;

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Only a good stop bit gets echoed, the value passes unchanged
	function automatic logic echo_expected(input uart_byte_t data, input logic stop_bit);
		return (stop_bit === 1'b1);
	endfunction

	// Failures counted by all bound checkers
	function automatic int assertion_failures();
		return i_uart_echo_top.i_echo_relay.i_relay_assert.fail_count +
			i_uart_echo_top.i_rx_fifo.i_fifo_assert.fail_count +
			i_uart_echo_top.i_tx_fifo.i_fifo_assert.fail_count +
			i_uart_echo_top.i_uart_tx.i_tx_assert.fail_count;
	endfunction

	task automatic abort_run();
		$display("=== FAIL ===");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %s expected 0x%0h got 0x%0h", name, expected, actual);
			abort_run();
		end
	endtask

	// Inputs change just after the rising edge
	task automatic align_drive();
		@(posedge clk);
		#1;
	endtask

	task automatic drive_bit(input logic level);
		rxd = level;
		repeat (BIT_CYCLES) @(posedge clk);
		#1;
	endtask

	// Start, data LSB first, chosen stop level
	task automatic send_frame(input uart_byte_t data, input logic stop_bit);
		drive_bit(1'b0);
		for (int i = 0; i < 8; i++)
			drive_bit(data[i]);
		drive_bit(stop_bit);
		// Line must go high again or the next start bit has no edge
		if (!stop_bit)
			drive_bit(1'b1);
	endtask

	task automatic send_and_predict(input uart_byte_t data, input logic stop_bit);
		if (echo_expected(data, stop_bit))
			exp_q.push_back(data);
		send_frame(data, stop_bit);
	endtask

	task automatic wait_for_echoes(input int max_cycles);
		int cycles;
		cycles = 0;
		while ((exp_q.size() != 0 || got_q.size() != 0) && cycles < max_cycles)
		begin
			@(negedge clk);
			cycles++;
		end
		if (exp_q.size() != 0 || got_q.size() != 0)
		begin
			$display("Timeout after %0d cycles waiting for echoed frames on txd", max_cycles);
			abort_run();
		end
	endtask

	// Any extra frame in this window hits the comparator
	task automatic expect_silence(input int cycles);
		repeat (cycles) @(negedge clk);
		check_value("decoded_frames_pending", 0, got_q.size());
		check_value("decoder_busy", 0, decoding);
	endtask

	//////////////////////////////////////////////////
	// Assertion monitor
	//////////////////////////////////////////////////

	always @(negedge clk)
	begin
		if (assertion_failures() != 0)
		begin
			$display("An assertion in the bound checkers failed");
			abort_run();
		end
	end

	//////////////////////////////////////////////////
	// txd decoder
	//////////////////////////////////////////////////

	// Samples on the falling clock edge, where txd is stable
	initial
	begin : decoder
		uart_byte_t value;
		decoding = 1'b0;
		forever
		begin
			@(negedge clk);
			if (arst_n === 1'b1 && txd === 1'b0)
			begin
				decoding = 1'b1;
				// Middle of the start bit
				repeat (`UART_ECHO_HALF_BIT - 1) @(negedge clk);
				if (txd !== 1'b0)
				begin
					$display("Start bit on txd did not stay low to mid-bit");
					abort_run();
				end
				for (int i = 0; i < 8; i++)
				begin
					repeat (BIT_CYCLES) @(negedge clk);
					value[i] = txd;
				end
				repeat (BIT_CYCLES) @(negedge clk);
				if (txd !== 1'b1)
				begin
					$display("Stop bit on txd was low");
					abort_run();
				end
				got_q.push_back(value);
				decoding = 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////
	// Comparator
	//////////////////////////////////////////////////

	initial
	begin : compare
		uart_byte_t got;
		uart_byte_t want;
		forever
		begin
			@(negedge clk);
			if (got_q.size() > 0)
			begin
				got = got_q.pop_front();
				if (exp_q.size() == 0)
				begin
					$display("Frame with value 0x%02h on txd was never expected", got);
					abort_run();
				end
				else
				begin
					want = exp_q.pop_front();
					check_value("txd_byte", want, got);
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial
	begin
		logic       stop_bit;
		uart_byte_t data;
		clk       = 1'b0;
		arst_n    = 1'b0;
		rxd       = 1'b1;
		rng_state = 32'd18;

		// Reset for 5 cycles
		repeat (5) @(posedge clk);
		#1;
		arst_n = 1'b1;

		// Idle line after reset
		repeat (20 * BIT_CYCLES)
		begin
			@(negedge clk);
			check_value("txd", 1, txd);
		end

		// Single echo
		align_drive();
		send_and_predict(8'hA5, 1'b1);
		wait_for_echoes(4 * FRAME_CYCLES);

		// Back to back burst
		align_drive();
		for (int i = 0; i < 12; i++)
		begin
			rng_state = xorshift32(rng_state);
			send_and_predict(rng_state[7:0], 1'b1);
		end
		wait_for_echoes(6 * FRAME_CYCLES);

		// Bad stop bit then a good frame
		align_drive();
		rng_state = xorshift32(rng_state);
		send_and_predict(rng_state[7:0], 1'b0);
		send_and_predict(8'h3C, 1'b1);
		wait_for_echoes(6 * FRAME_CYCLES);
		expect_silence(3 * FRAME_CYCLES);

		// Mixed stream, about one frame in four bad
		align_drive();
		for (int i = 0; i < 20; i++)
		begin
			rng_state = xorshift32(rng_state);
			data      = rng_state[7:0];
			stop_bit  = (rng_state[9:8] != 2'b00);
			send_and_predict(data, stop_bit);
		end
		wait_for_echoes(6 * FRAME_CYCLES);
		expect_silence(3 * FRAME_CYCLES);

		if (assertion_failures() == 0)
		begin
			$display("=== PASS ===");
			$finish;
		end
		else
		begin
			$display("An assertion in the bound checkers failed");
			abort_run();
		end
	end

endmodule

`default_nettype wire

//--- uart_echo.f
+incdir+include
logic/uart_echo_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/byte_fifo.sv
logic/echo_relay.sv
logic/uart_echo_top.sv
verification/uart_echo_assert.sv
verification/uart_echo_tb.sv
